// ==== ing_beat_fifo.sv ====
// Show-ahead beat FIFO
`default_nettype none

`include "ing_cfg.svh"

module ing_beat_fifo (
    input  var logic              ing_phys_ports,
    input  var logic              arst_n,
    input  var logic              push,
    input  var ing_pkg::ing_beat_t push_beat,
    input  var logic              pop,
    output ing_pkg::ing_beat_t    head_beat,
    output logic                  empty
);

    localparam int DEPTH = `ING_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ing_pkg::ing_beat_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign head_beat = mem[rd_ptr];

    // Storage array
    always_ff @(posedge ing_phys_ports) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge ing_phys_ports or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // A push into a full FIFO means the sender ignored its credits
    assert property (@(posedge ing_phys_ports) disable iff (!arst_n) !(push && full && !pop));

    // The merge must only pop a head that exists
    assert property (@(posedge ing_phys_ports) disable iff (!arst_n) pop |-> !empty);

endmodule

`default_nettype wire

// ==== ing_cfg.svh ====
// Ingress front end configuration
`ifndef ING_CFG_SVH
`define ING_CFG_SVH

//////////////////////////////
// Beat format
//////////////////////////////

// Bytes carried by one beat
`define ING_DATA_BYTES 4

// Payload width in bits
`define ING_DATA_WIDTH (`ING_DATA_BYTES * 8)

//////////////////////////////
// Port array
//////////////////////////////

// Two physical ingress ports
`define ING_NUM_PORTS 2

// Width of the source port tag
`define ING_PORT_BITS $clog2(`ING_NUM_PORTS)

//////////////////////////////
// Buffering and credits
//////////////////////////////

// Per-port FIFO entries, also the sender's credit count after reset
`define ING_FIFO_DEPTH 8

// Credits held toward the core after reset
`define ING_CORE_CREDITS 4

// Width of each statistics counter
`define ING_CNT_WIDTH 32

`endif

// ==== ing_pkg.sv ====
// Ingress front end types
`default_nettype none

`include "ing_cfg.svh"

package ing_pkg;

    //////////////////////////////
    // Beats
    //////////////////////////////

    // One framed beat from a physical port
    typedef struct packed {
        logic [`ING_DATA_WIDTH-1:0] data;
        logic [`ING_DATA_BYTES-1:0] keep;
        logic                       last;
    } ing_beat_t;

    // Beat on the converged core stream, tagged with its source
    typedef struct packed {
        ing_beat_t                  beat;
        logic [`ING_PORT_BITS-1:0]  port;
    } ing_core_beat_t;

    //////////////////////////////
    // Statistics
    //////////////////////////////

    typedef struct packed {
        logic [`ING_CNT_WIDTH-1:0] frames;
        logic [`ING_CNT_WIDTH-1:0] bytes;
        logic [`ING_CNT_WIDTH-1:0] drops;
    } ing_cnts_t;

    //////////////////////////////
    // FSM states
    //////////////////////////////

    typedef enum logic [1:0] {
        GATE_IDLE,
        GATE_PASS,
        GATE_DROP
    } gate_state_e;

    typedef enum logic {
        MERGE_IDLE,
        MERGE_FRAME
    } merge_state_e;

endpackage

`default_nettype wire

// ==== ing_port_adapt.sv ====
// Ingress port adapter
`default_nettype none

`include "ing_cfg.svh"

module ing_port_adapt (
    input  var logic               ing_phys_ports,
    input  var logic               arst_n,
    input  var logic               in_valid,
    input  var ing_pkg::ing_beat_t in_beat,
    output logic                   in_credit,
    input  var logic               enable,
    input  var logic               cnts_clear,
    output ing_pkg::ing_cnts_t     cnts,
    output logic                   connected,
    input  var logic               pop,
    output ing_pkg::ing_beat_t     fifo_beat,
    output logic                   fifo_empty
);

    localparam int PEND_W = $clog2(`ING_FIFO_DEPTH + 1);
    localparam int KEEP_W = $clog2(`ING_DATA_BYTES + 1);

    ing_pkg::gate_state_e state;

    logic              pass_beat;
    logic              drop_beat;
    logic [KEEP_W-1:0] keep_bytes;
    logic [PEND_W-1:0] credit_pend;
    logic [PEND_W:0]   credit_due;

    //////////////////////////////
    // Frame gate
    //////////////////////////////

    // Decision is taken on the first beat and held until last
    always_comb begin
        pass_beat = 1'b0;
        drop_beat = 1'b0;
        if (in_valid) begin
            case (state)
                ing_pkg::GATE_PASS: pass_beat = 1'b1;
                ing_pkg::GATE_DROP: drop_beat = 1'b1;
                default: begin
                    pass_beat = enable;
                    drop_beat = !enable;
                end
            endcase
        end
    end

    always_ff @(posedge ing_phys_ports or negedge arst_n) begin
        if (!arst_n) begin
            state <= ing_pkg::GATE_IDLE;
        end else if (in_valid) begin
            if (in_beat.last) begin
                state <= ing_pkg::GATE_IDLE;
            end else if (pass_beat) begin
                state <= ing_pkg::GATE_PASS;
            end else begin
                state <= ing_pkg::GATE_DROP;
            end
        end
    end

    assign connected = (state == ing_pkg::GATE_PASS) ||
                       ((state == ing_pkg::GATE_IDLE) && enable);

    //////////////////////////////
    // Statistics
    //////////////////////////////

    always_comb begin
        keep_bytes = '0;
        for (int i = 0; i < `ING_DATA_BYTES; i++) begin
            keep_bytes = keep_bytes + KEEP_W'(in_beat.keep[i]);
        end
    end

    // Clear wins over a same-cycle increment
    always_ff @(posedge ing_phys_ports or negedge arst_n) begin
        if (!arst_n) begin
            cnts <= '0;
        end else if (cnts_clear) begin
            cnts <= '0;
        end else begin
            if (pass_beat) begin
                cnts.bytes <= cnts.bytes + `ING_CNT_WIDTH'(keep_bytes);
            end
            if (pass_beat && in_beat.last) begin
                cnts.frames <= cnts.frames + 1'b1;
            end
            if (drop_beat && in_beat.last) begin
                cnts.drops <= cnts.drops + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Buffer and credit return
    //////////////////////////////

    ing_beat_fifo beat_fifo_i (
        .ing_phys_ports (ing_phys_ports),
        .arst_n         (arst_n),
        .push           (pass_beat),
        .push_beat      (in_beat),
        .pop            (pop),
        .head_beat      (fifo_beat),
        .empty          (fifo_empty)
    );

    // One credit leaves per cycle, any surplus waits in credit_pend
    assign credit_due = {1'b0, credit_pend} + (PEND_W + 1)'(pop) + (PEND_W + 1)'(drop_beat);

    always_ff @(posedge ing_phys_ports or negedge arst_n) begin
        if (!arst_n) begin
            in_credit   <= 1'b0;
            credit_pend <= '0;
        end else begin
            in_credit <= (credit_due != '0);
            if (credit_due != '0) begin
                credit_pend <= PEND_W'(credit_due - 1'b1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== ing_port_array_adapt.sv ====
// Two-port ingress array with merge
`default_nettype none

`include "ing_cfg.svh"

module ing_port_array_adapt (
    input  var logic                      ing_phys_ports,
    input  var logic                      arst_n,
    input  var logic [`ING_NUM_PORTS-1:0] in_valid,
    input  var ing_pkg::ing_beat_t        in_beat [`ING_NUM_PORTS],
    output logic [`ING_NUM_PORTS-1:0]     in_credit,
    input  var logic [`ING_NUM_PORTS-1:0] enable,
    input  var logic [`ING_NUM_PORTS-1:0] cnts_clear,
    output ing_pkg::ing_cnts_t            cnts [`ING_NUM_PORTS],
    output logic [`ING_NUM_PORTS-1:0]     connected,
    output logic                          core_valid,
    output ing_pkg::ing_core_beat_t       core_beat,
    input  var logic                      core_credit
);

    ing_pkg::ing_beat_t          fifo_beat [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0]   fifo_empty;
    logic [`ING_NUM_PORTS-1:0]   pop;

    // One adapter per physical port
    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : port_g
        ing_port_adapt port_adapt_i (
            .ing_phys_ports (ing_phys_ports),
            .arst_n         (arst_n),
            .in_valid       (in_valid[p]),
            .in_beat        (in_beat[p]),
            .in_credit      (in_credit[p]),
            .enable         (enable[p]),
            .cnts_clear     (cnts_clear[p]),
            .cnts           (cnts[p]),
            .connected      (connected[p]),
            .pop            (pop[p]),
            .fifo_beat      (fifo_beat[p]),
            .fifo_empty     (fifo_empty[p])
        );
    end

    ing_port_merge port_merge_i (
        .ing_phys_ports (ing_phys_ports),
        .arst_n         (arst_n),
        .fifo_beat      (fifo_beat),
        .fifo_empty     (fifo_empty),
        .pop            (pop),
        .core_valid     (core_valid),
        .core_beat      (core_beat),
        .core_credit    (core_credit)
    );

endmodule

`default_nettype wire

// ==== ing_port_merge.sv ====
// Round-robin frame merge toward the core
`default_nettype none

`include "ing_cfg.svh"

module ing_port_merge (
    input  var logic                      ing_phys_ports,
    input  var logic                      arst_n,
    input  var ing_pkg::ing_beat_t        fifo_beat [`ING_NUM_PORTS],
    input  var logic [`ING_NUM_PORTS-1:0] fifo_empty,
    output logic [`ING_NUM_PORTS-1:0]     pop,
    output logic                          core_valid,
    output ing_pkg::ing_core_beat_t       core_beat,
    input  var logic                      core_credit
);

    localparam int CRED_W = $clog2(`ING_CORE_CREDITS + 1);

    ing_pkg::merge_state_e state;

    logic [`ING_PORT_BITS-1:0] cur_port;
    logic [`ING_PORT_BITS-1:0] last_port;
    logic [`ING_PORT_BITS-1:0] pick_port;
    logic [`ING_PORT_BITS-1:0] active_port;
    logic [CRED_W-1:0]         core_cred;
    logic                      send;

    //////////////////////////////
    // Port choice
    //////////////////////////////

    // Both ready means the port not served last goes next
    always_comb begin
        if (!fifo_empty[0] && !fifo_empty[1]) begin
            pick_port = ~last_port;
        end else if (!fifo_empty[0]) begin
            pick_port = 1'b0;
        end else begin
            pick_port = 1'b1;
        end
    end

    // Mid-frame the port is locked
    assign active_port = (state == ing_pkg::MERGE_FRAME) ? cur_port : pick_port;
    assign send        = !fifo_empty[active_port] && (core_cred != '0);

    always_comb begin
        pop              = '0;
        pop[active_port] = send;
    end

    always_ff @(posedge ing_phys_ports or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ing_pkg::MERGE_IDLE;
            cur_port  <= '0;
            last_port <= '1;
        end else if (send) begin
            cur_port <= active_port;
            if (fifo_beat[active_port].last) begin
                state     <= ing_pkg::MERGE_IDLE;
                last_port <= active_port;
            end else begin
                state <= ing_pkg::MERGE_FRAME;
            end
        end
    end

    //////////////////////////////
    // Core output and credits
    //////////////////////////////

    always_ff @(posedge ing_phys_ports or negedge arst_n) begin
        if (!arst_n) begin
            core_valid <= 1'b0;
            core_cred  <= CRED_W'(`ING_CORE_CREDITS);
        end else begin
            core_valid <= send;
            case ({send, core_credit})
                2'b10:   core_cred <= core_cred - 1'b1;
                2'b01:   core_cred <= core_cred + 1'b1;
                default: core_cred <= core_cred;
            endcase
        end
    end

    always_ff @(posedge ing_phys_ports) begin
        if (send) begin
            core_beat.beat <= fifo_beat[active_port];
            core_beat.port <= active_port;
        end
    end

    // The core must not return more credits than it was given
    assert property (@(posedge ing_phys_ports) disable iff (!arst_n)
        core_credit |-> (send || (core_cred != CRED_W'(`ING_CORE_CREDITS))));

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
ing_pkg.sv
ing_beat_fifo.sv
ing_port_adapt.sv
ing_port_merge.sv
ing_port_array_adapt.sv
tb_clk_gen.sv
tb_ing_port_array_adapt.sv

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
`default_nettype none

module tb_clk_gen (
    output logic ing_phys_ports,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 50ns;

    initial begin
        ing_phys_ports = 1'b0;
        forever begin
            #HALF_PERIOD ing_phys_ports = !ing_phys_ports;
        end
    end

    // Held low over the first 3 rising edges
    initial begin
        arst_n = 1'b0;
        #(6 * HALF_PERIOD) arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_ing_port_array_adapt.sv ====
// Ingress array testbench
`default_nettype none

`include "ing_cfg.svh"

module tb_ing_port_array_adapt;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS       = `ING_NUM_PORTS;
    localparam int FIFO_DEPTH      = `ING_FIFO_DEPTH;
    localparam int CORE_CREDITS    = `ING_CORE_CREDITS;
    localparam int FRAMES          = 40;
    localparam int PHASES          = 2;
    localparam int MAX_BEATS       = 6;
    localparam int WATCHDOG_CYCLES = PHASES * NUM_PORTS * FRAMES * MAX_BEATS * 16;

    logic                     ing_phys_ports;
    logic                     arst_n;
    logic [NUM_PORTS-1:0]     in_valid;
    ing_pkg::ing_beat_t       in_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0]     in_credit;
    logic [NUM_PORTS-1:0]     enable;
    logic [NUM_PORTS-1:0]     cnts_clear;
    ing_pkg::ing_cnts_t       cnts [NUM_PORTS];
    logic [NUM_PORTS-1:0]     connected;
    logic                     core_valid;
    ing_pkg::ing_core_beat_t  core_beat;
    logic                     core_credit;

    // Reference model state
    logic [31:0]          rng_state;
    int                   cycle;
    int                   credits [NUM_PORTS];
    int                   frames_left [NUM_PORTS];
    int                   beats_left [NUM_PORTS];
    int                   gap [NUM_PORTS];
    bit                   started [NUM_PORTS];
    bit                   gate_pass [NUM_PORTS];
    ing_pkg::ing_beat_t   exp_q [NUM_PORTS][$];
    int                   exp_cyc [NUM_PORTS][$];
    int                   exp_frames [NUM_PORTS];
    int                   exp_bytes [NUM_PORTS];
    int                   exp_drops [NUM_PORTS];
    int                   core_out;
    int                   core_pend;
    bit                   out_mid_frame;
    int                   frame_port;
    int                   last_frame_port;

    tb_clk_gen clk_gen_i (
        .ing_phys_ports (ing_phys_ports),
        .arst_n         (arst_n)
    );

    ing_port_array_adapt ing_port_array_adapt_i (
        .ing_phys_ports (ing_phys_ports),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_beat        (in_beat),
        .in_credit      (in_credit),
        .enable         (enable),
        .cnts_clear     (cnts_clear),
        .cnts           (cnts),
        .connected      (connected),
        .core_valid     (core_valid),
        .core_beat      (core_beat),
        .core_credit    (core_credit)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int count_bytes(input logic [`ING_DATA_BYTES-1:0] keep);
        int n;
        n = 0;
        for (int i = 0; i < `ING_DATA_BYTES; i++) begin
            if (keep[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at cycle %0d", cycle);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            report_failure("Value mismatch");
        end
    endtask

    //////////////////////////////
    // Output side
    //////////////////////////////

    task automatic check_core_beat();
        int p;
        int other;
        ing_pkg::ing_beat_t exp_beat;
        p = int'(core_beat.port);
        other = 1 - p;
        if (exp_q[p].size() == 0) begin
            report_failure($sformatf("Port %0d delivered a beat that was never passed", p));
        end
        if (!out_mid_frame) begin
            // Other port waiting at the decision edge must be served first
            if (p == last_frame_port && exp_q[other].size() != 0 &&
                exp_cyc[other][0] <= cycle - 1) begin
                report_failure("Merge served one port twice while the other was waiting");
            end
            frame_port = p;
        end else begin
            check_value("frame contiguity", frame_port, p);
        end
        exp_beat = exp_q[p].pop_front();
        void'(exp_cyc[p].pop_front());
        check_value($sformatf("core beat port %0d", p), exp_beat, core_beat.beat);
        out_mid_frame = !core_beat.beat.last;
        if (core_beat.beat.last) begin
            last_frame_port = p;
        end
    endtask

    task automatic observe();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_credit[p]) begin
                credits[p]++;
            end
            check_value($sformatf("sender credits bound port %0d", p), 1'b1,
                        credits[p] <= FIFO_DEPTH);
        end
        if (core_credit) begin
            core_out--;
        end
        if (core_valid) begin
            core_out++;
            core_pend++;
            check_value("core credits outstanding", 1'b1, core_out <= CORE_CREDITS);
            check_core_beat();
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic step_port(input int p);
        ing_pkg::ing_beat_t beat;
        logic [31:0] r;
        // Gate rule as seen on connected
        if (started[p]) begin
            check_value($sformatf("connected port %0d", p), gate_pass[p], connected[p]);
        end else begin
            check_value($sformatf("connected idle port %0d", p), enable[p], connected[p]);
        end
        r = next_random();
        in_valid[p] = 1'b0;
        if (r[2:0] == 3'd0) begin
            enable[p] = !enable[p];
        end
        if (beats_left[p] == 0) begin
            if (gap[p] != 0) begin
                gap[p]--;
            end else if (frames_left[p] != 0) begin
                frames_left[p]--;
                beats_left[p] = 1 + int'(r[10:8]) % MAX_BEATS;
            end
        end
        if (beats_left[p] != 0 && credits[p] != 0 && r[5:4] != 2'd0) begin
            beat.data = next_random();
            beat.last = (beats_left[p] == 1);
            beat.keep = '1;
            if (beat.last && r[15:12] != 4'd0) begin
                beat.keep = r[15:12];
            end
            // Gate decision follows enable on the first beat
            if (!started[p]) begin
                gate_pass[p] = enable[p];
                started[p] = 1'b1;
            end
            in_valid[p] = 1'b1;
            in_beat[p] = beat;
            credits[p]--;
            beats_left[p]--;
            if (gate_pass[p]) begin
                exp_q[p].push_back(beat);
                exp_cyc[p].push_back(cycle + 1);
                exp_bytes[p] += count_bytes(beat.keep);
                if (beat.last) begin
                    exp_frames[p]++;
                end
            end else if (beat.last) begin
                exp_drops[p]++;
            end
            if (beat.last) begin
                started[p] = 1'b0;
                gap[p] = int'(r[19:17]);
            end
        end
    endtask

    // Core returns credits after a random delay
    task automatic step_core();
        logic [31:0] r;
        r = next_random();
        core_credit = 1'b0;
        if (core_pend != 0 && r[1:0] != 2'd0) begin
            core_credit = 1'b1;
            core_pend--;
        end
    endtask

    task automatic step();
        @(posedge ing_phys_ports);
        #10;
        cycle++;
        observe();
        for (int p = 0; p < NUM_PORTS; p++) begin
            step_port(p);
        end
        step_core();
    endtask

    task automatic run_phase(input int frames);
        for (int p = 0; p < NUM_PORTS; p++) begin
            frames_left[p] = frames;
        end
        do begin
            step();
        end while (frames_left[0] != 0 || frames_left[1] != 0 ||
                   beats_left[0] != 0 || beats_left[1] != 0);
    endtask

    task automatic drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || core_pend != 0) begin
            step();
        end
        // Queued credit pulses leave one per cycle
        repeat (FIFO_DEPTH + 2) step();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("drained credits port %0d", p), FIFO_DEPTH, credits[p]);
        end
    endtask

    task automatic check_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("frames port %0d", p), exp_frames[p], cnts[p].frames);
            check_value($sformatf("bytes port %0d", p), exp_bytes[p], cnts[p].bytes);
            check_value($sformatf("drops port %0d", p), exp_drops[p], cnts[p].drops);
        end
    endtask

    task automatic clear_counters();
        cnts_clear = '1;
        step();
        cnts_clear = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_frames[p] = 0;
            exp_bytes[p] = 0;
            exp_drops[p] = 0;
        end
        check_counters();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        in_valid = '0;
        enable = '1;
        cnts_clear = '0;
        core_credit = 1'b0;
        rng_state = 32'd80706;
        cycle = 0;
        core_out = 0;
        core_pend = 0;
        out_mid_frame = 1'b0;
        frame_port = 0;
        last_frame_port = 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_beat[p] = '0;
            credits[p] = FIFO_DEPTH;
            frames_left[p] = 0;
            beats_left[p] = 0;
            gap[p] = 0;
            started[p] = 1'b0;
            gate_pass[p] = 1'b0;
            exp_frames[p] = 0;
            exp_bytes[p] = 0;
            exp_drops[p] = 0;
        end
        wait (arst_n === 1'b1);
        check_value("core_valid after reset", 1'b0, core_valid);
        check_value("in_credit after reset", '0, in_credit);
        run_phase(FRAMES);
        drain();
        check_counters();
        clear_counters();
        run_phase(FRAMES);
        drain();
        check_counters();
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog sized from frame count and longest frame
    initial begin
        #(WATCHDOG_CYCLES * 100ns);
        report_failure("Watchdog expired before all frames were delivered");
    end

endmodule

`default_nettype wire
